//--- source/eth_defines.svh
`ifndef ETH_DEFINES_SVH
`define ETH_DEFINES_SVH

//////////////////////////////////////////////////////////////////////
// Frame stream
//////////////////////////////////////////////////////////////////////

// Frame lengths in bytes, trailer included
`define ETH_UDP_LEN       66
`define ETH_ARP_LEN       64
`define ETH_ICMP_LEN      78

`define ETH_GROUP_FRAMES  5    // Frames of one kind before rotating
`define ETH_GAP_CYCLES    16   // Idle cycles after each last byte

// Header fields
`define ETH_FPGA_MAC      48'h00D0_0800_0002
`define ETH_HOST_MAC      48'h0024_7EDF_CA5E
`define ETH_FPGA_IP       32'hC0A8_006E   // 192.168.0.110
`define ETH_HOST_IP       32'hC0A8_0077   // 192.168.0.119
`define ETH_UDP_PORT      16'd8080
`define ETH_TYPE_IP       16'h0800
`define ETH_TYPE_ARP      16'h0806
`define ETH_UDP_FLAG      32'hEEBA_EEBA

//////////////////////////////////////////////////////////////////////
// Block writer
//////////////////////////////////////////////////////////////////////

`define BLK_BASE_ADDR     32'h1000_0000
`define BLK_SUM_OFFSET    32'h0000_1000
`define BLK_WORDS         32
`define BLK_PERIOD        1024   // Timer period in cycles

`endif

//--- source/eth_pkg.sv
package eth_pkg;

	// Stream side
	typedef logic [7:0] byte_t;
	typedef logic [6:0] frame_idx_t;   // Byte index within a frame

	typedef enum logic [1:0] {
		KIND_UDP,
		KIND_ARP,
		KIND_ICMP
	} frame_kind_e;

	typedef enum logic {
		SEQ_SEND,
		SEQ_GAP
	} seq_state_e;

	// AXI side
	typedef logic [31:0] axi_addr_t;
	typedef logic [31:0] axi_data_t;
	typedef logic [23:0] blk_seq_t;    // Block number, shifted into data bits 31:8

	typedef enum logic [1:0] {
		BLK_IDLE,
		BLK_DATA,
		BLK_SUM
	} blk_state_e;

	typedef enum logic [1:0] {
		AXI_IDLE,
		AXI_SEND,
		AXI_RESP
	} axi_state_e;

endpackage

//--- source/wr_req_if.sv
`timescale 1ns/1ps

// Single-word write request, one outstanding
interface wr_req_if import eth_pkg::*; ();

	logic      req_valid;
	logic      req_ready;
	logic      req_done;    // One cycle on B accept
	axi_addr_t req_addr;
	axi_data_t req_data;

	modport writer (
		output req_valid,
		output req_addr,
		output req_data,
		input  req_ready,
		input  req_done
	);

	modport engine (
		input  req_valid,
		input  req_addr,
		input  req_data,
		output req_ready,
		output req_done
	);

endinterface

//--- source/frame_rom.sv
`timescale 1ns/1ps
`include "eth_defines.svh"

module frame_rom import eth_pkg::*; (
	input  frame_kind_e kind,
	input  frame_idx_t  idx,
	output byte_t       data
);

	localparam int UDP_W  = 8 * `ETH_UDP_LEN;
	localparam int ARP_W  = 8 * `ETH_ARP_LEN;
	localparam int ICMP_W = 8 * `ETH_ICMP_LEN;
	localparam int ROM_W  = ICMP_W;   // Longest frame

	//////////////////////////////////////////////////////////////////////
	// Frame images, first byte in the top bits
	//////////////////////////////////////////////////////////////////////

	localparam logic [UDP_W-1:0] UDP_FRAME = {
		`ETH_FPGA_MAC, `ETH_HOST_MAC, `ETH_TYPE_IP,
		16'h4500, 16'h0030, 16'h0012, 16'h4000,   // Ver/TOS, total 48, id, flags
		16'h8011, 16'h0000,                       // TTL, UDP proto, no checksum
		`ETH_HOST_IP, `ETH_FPGA_IP,
		`ETH_UDP_PORT, `ETH_UDP_PORT, 16'd28, 16'h0000,
		`ETH_UDP_FLAG,
		128'h1234_5611_1134_5678_1234_5678_AABB_CCDD,
		32'hCFD9_3530                             // Fixed trailer
	};

	// Broadcast request from the host, padded to minimum size
	localparam logic [ARP_W-1:0] ARP_FRAME = {
		48'hFFFF_FFFF_FFFF, `ETH_HOST_MAC, `ETH_TYPE_ARP,
		64'h0001_0800_0604_0001,
		`ETH_HOST_MAC, `ETH_HOST_IP,
		48'h0, `ETH_FPGA_IP,
		144'h0,
		32'h59FB_0258
	};

	localparam logic [ICMP_W-1:0] ICMP_FRAME = {
		`ETH_FPGA_MAC, `ETH_HOST_MAC, `ETH_TYPE_IP,
		16'h4500, 16'h003C, 16'h71A0, 16'h0000,
		16'h8001, 16'h0000,                       // ICMP proto
		`ETH_HOST_IP, `ETH_FPGA_IP,
		16'h0800, 16'h4D56, 16'h0001, 16'h0005,   // Echo request, id, seq
		256'h6162_6364_6566_6768_696A_6B6C_6D6E_6F70_7172_7374_7576_7761_6263_6465_6667_6869,
		32'hC034_2A1A
	};

	logic [ROM_W-1:0] frame_bits;
	logic [ROM_W-1:0] shifted;

	// Left align so every kind shares one byte selector
	always_comb begin
		case (kind)
			KIND_ARP:  frame_bits = {ARP_FRAME, {(ROM_W - ARP_W){1'b0}}};
			KIND_ICMP: frame_bits = ICMP_FRAME;
			default:   frame_bits = {UDP_FRAME, {(ROM_W - UDP_W){1'b0}}};
		endcase
	end

	assign shifted = frame_bits << {idx, 3'b000};
	assign data    = shifted[ROM_W-1 -: 8];   // Zero past the frame end

endmodule

//--- source/frame_sequencer.sv
`timescale 1ns/1ps
`include "eth_defines.svh"

module frame_sequencer import eth_pkg::*; (
	input  logic  sys_clk,
	input  logic  sys_rst,
	output byte_t rx_data,
	output logic  rx_valid,
	output logic  rx_last,
	input  logic  rx_ready
);

	localparam int GAP_W = $clog2(`ETH_GAP_CYCLES + 1);
	localparam int GRP_W = $clog2(`ETH_GROUP_FRAMES + 1);

	seq_state_e       state;
	frame_kind_e      kind;
	frame_idx_t       idx;
	frame_idx_t       last_idx;
	logic [GRP_W-1:0] frame_cnt;   // Frames sent in this group
	logic [GAP_W-1:0] gap_cnt;
	logic             xfer;

	function automatic frame_kind_e next_kind(input frame_kind_e cur);
		case (cur)
			KIND_UDP: return KIND_ARP;
			KIND_ARP: return KIND_ICMP;
			default:  return KIND_UDP;
		endcase
	endfunction

	frame_rom u_frame_rom (
		.kind (kind),
		.idx  (idx),
		.data (rx_data)
	);

	always_comb begin
		case (kind)
			KIND_ARP:  last_idx = frame_idx_t'(`ETH_ARP_LEN - 1);
			KIND_ICMP: last_idx = frame_idx_t'(`ETH_ICMP_LEN - 1);
			default:   last_idx = frame_idx_t'(`ETH_UDP_LEN - 1);
		endcase
	end

	assign xfer    = rx_valid && rx_ready;
	assign rx_last = rx_valid && (idx == last_idx);

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			state     <= SEQ_GAP;
			gap_cnt   <= GAP_W'(`ETH_GAP_CYCLES - 1);   // Start right after reset
			kind      <= KIND_UDP;
			frame_cnt <= '0;
			idx       <= '0;
			rx_valid  <= 1'b0;
		end else begin
			case (state)
				SEQ_SEND: begin
					if (xfer && rx_last) begin
						idx      <= '0;
						rx_valid <= 1'b0;
						gap_cnt  <= '0;
						state    <= SEQ_GAP;
						if (frame_cnt == GRP_W'(`ETH_GROUP_FRAMES - 1)) begin
							frame_cnt <= '0;
							kind      <= next_kind(kind);
						end else begin
							frame_cnt <= frame_cnt + 1'b1;
						end
					end else if (xfer) begin
						idx <= idx + 1'b1;
					end
				end

				SEQ_GAP: begin
					if (gap_cnt == GAP_W'(`ETH_GAP_CYCLES - 1)) begin
						rx_valid <= 1'b1;
						state    <= SEQ_SEND;
					end else begin
						gap_cnt <= gap_cnt + 1'b1;
					end
				end

				default: state <= SEQ_GAP;
			endcase
		end
	end

endmodule

//--- source/block_writer.sv
`timescale 1ns/1ps
`include "eth_defines.svh"

module block_writer import eth_pkg::*; (
	input logic      sys_clk,
	input logic      sys_rst,
	wr_req_if.writer req
);

	localparam int TMR_W  = $clog2(`BLK_PERIOD);
	localparam int WORD_W = $clog2(`BLK_WORDS);

	blk_state_e        state;
	logic [TMR_W-1:0]  timer;
	logic              tick;
	blk_seq_t          seq_num;
	logic [WORD_W-1:0] word_idx;
	axi_data_t         sum;
	axi_data_t         word_data;
	logic              pending;   // Request taken, waiting for done

	//////////////////////////////////////////////////////////////////////
	// Period timer, free running
	//////////////////////////////////////////////////////////////////////

	assign tick = (timer == TMR_W'(`BLK_PERIOD - 1));

	always_ff @(posedge sys_clk) begin
		if (sys_rst)
			timer <= '0;
		else
			timer <= tick ? '0 : timer + 1'b1;
	end

	//////////////////////////////////////////////////////////////////////
	// Request side
	//////////////////////////////////////////////////////////////////////

	assign word_data     = (axi_data_t'(seq_num) << 8) + axi_data_t'(word_idx);
	assign req.req_valid = (state != BLK_IDLE) && !pending;
	assign req.req_data  = (state == BLK_SUM) ? sum : word_data;
	assign req.req_addr  = (state == BLK_SUM) ?
		axi_addr_t'(`BLK_BASE_ADDR + `BLK_SUM_OFFSET) :
		axi_addr_t'(`BLK_BASE_ADDR) + axi_addr_t'({word_idx, 2'b00});

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			state    <= BLK_IDLE;
			pending  <= 1'b0;
			word_idx <= '0;
			seq_num  <= '0;
		end else begin
			if (req.req_valid && req.req_ready)
				pending <= 1'b1;
			else if (req.req_done)
				pending <= 1'b0;

			case (state)
				BLK_IDLE: begin
					if (tick) begin   // Wraps while busy are dropped
						word_idx <= '0;
						sum      <= '0;
						state    <= BLK_DATA;
					end
				end

				BLK_DATA: begin
					if (req.req_done) begin
						sum      <= sum + word_data;
						word_idx <= word_idx + 1'b1;
						if (word_idx == WORD_W'(`BLK_WORDS - 1))
							state <= BLK_SUM;
					end
				end

				BLK_SUM: begin
					if (req.req_done) begin
						seq_num <= seq_num + 1'b1;
						state   <= BLK_IDLE;
					end
				end

				default: state <= BLK_IDLE;
			endcase
		end
	end

endmodule

//--- source/axil_write_master.sv
`timescale 1ns/1ps

module axil_write_master import eth_pkg::*; (
	input  logic       sys_clk,
	input  logic       sys_rst,
	wr_req_if.engine   req,
	output axi_addr_t  m_axi_awaddr,
	output logic       m_axi_awvalid,
	input  logic       m_axi_awready,
	output axi_data_t  m_axi_wdata,
	output logic       m_axi_wvalid,
	input  logic       m_axi_wready,
	input  logic [1:0] m_axi_bresp,
	input  logic       m_axi_bvalid,
	output logic       m_axi_bready,
	output logic       wr_error
);

	axi_state_e state;
	logic       take;
	logic       aw_left;   // AW still open after this cycle
	logic       w_left;

	assign req.req_ready = (state == AXI_IDLE);
	assign take          = req.req_valid && req.req_ready;
	assign m_axi_bready  = (state == AXI_RESP);
	assign req.req_done  = m_axi_bready && m_axi_bvalid;

	assign aw_left = m_axi_awvalid && !m_axi_awready;
	assign w_left  = m_axi_wvalid && !m_axi_wready;

	always_ff @(posedge sys_clk) begin
		if (take) begin
			m_axi_awaddr <= req.req_addr;
			m_axi_wdata  <= req.req_data;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			state         <= AXI_IDLE;
			m_axi_awvalid <= 1'b0;
			m_axi_wvalid  <= 1'b0;
		end else begin
			case (state)
				AXI_IDLE: begin
					if (take) begin
						m_axi_awvalid <= 1'b1;
						m_axi_wvalid  <= 1'b1;
						state         <= AXI_SEND;
					end
				end

				AXI_SEND: begin
					m_axi_awvalid <= aw_left;
					m_axi_wvalid  <= w_left;
					if (!aw_left && !w_left)
						state <= AXI_RESP;
				end

				AXI_RESP: if (m_axi_bvalid) state <= AXI_IDLE;

				default: state <= AXI_IDLE;
			endcase
		end
	end

	// Sticky until reset
	always_ff @(posedge sys_clk) begin
		if (sys_rst)
			wr_error <= 1'b0;
		else if (req.req_done && (m_axi_bresp != 2'b00))
			wr_error <= 1'b1;
	end

endmodule

//--- source/eth_traffic_gen.sv
`timescale 1ns/1ps

module eth_traffic_gen import eth_pkg::*; (
	input  logic       sys_clk,
	input  logic       sys_rst,

	// Frame stream
	output byte_t      rx_data,
	output logic       rx_valid,
	output logic       rx_last,
	input  logic       rx_ready,

	// AXI4-Lite write
	output axi_addr_t  m_axi_awaddr,
	output logic       m_axi_awvalid,
	input  logic       m_axi_awready,
	output axi_data_t  m_axi_wdata,
	output logic       m_axi_wvalid,
	input  logic       m_axi_wready,
	input  logic [1:0] m_axi_bresp,
	input  logic       m_axi_bvalid,
	output logic       m_axi_bready,
	output logic       wr_error
);

	wr_req_if wr_req ();

	frame_sequencer u_frame_sequencer (
		.sys_clk  (sys_clk),
		.sys_rst  (sys_rst),
		.rx_data  (rx_data),
		.rx_valid (rx_valid),
		.rx_last  (rx_last),
		.rx_ready (rx_ready)
	);

	block_writer u_block_writer (
		.sys_clk (sys_clk),
		.sys_rst (sys_rst),
		.req     (wr_req)
	);

	axil_write_master u_axil_write_master (
		.sys_clk       (sys_clk),
		.sys_rst       (sys_rst),
		.req           (wr_req),
		.m_axi_awaddr  (m_axi_awaddr),
		.m_axi_awvalid (m_axi_awvalid),
		.m_axi_awready (m_axi_awready),
		.m_axi_wdata   (m_axi_wdata),
		.m_axi_wvalid  (m_axi_wvalid),
		.m_axi_wready  (m_axi_wready),
		.m_axi_bresp   (m_axi_bresp),
		.m_axi_bvalid  (m_axi_bvalid),
		.m_axi_bready  (m_axi_bready),
		.wr_error      (wr_error)
	);

endmodule

//--- testbench/tb_eth_traffic_gen.sv
`timescale 1ns/1ps
`include "eth_defines.svh"

module tb_eth_traffic_gen import eth_pkg::*; ();

	localparam int FRAMES_RUN       = 18;
	localparam int BLOCKS_RUN       = 4;
	localparam int WRITES_PER_BLOCK = `BLK_WORDS + 1;
	localparam int ERR_WRITE        = 2 * WRITES_PER_BLOCK + 7;   // Word 7 of block 2
	localparam int TIMEOUT_CYCLES   = (BLOCKS_RUN + 1) * `BLK_PERIOD + 880;

	logic       sys_clk = 1'b0;
	logic       sys_rst;
	byte_t      rx_data;
	logic       rx_valid;
	logic       rx_last;
	logic       rx_ready;
	axi_addr_t  m_axi_awaddr;
	logic       m_axi_awvalid;
	logic       m_axi_awready;
	axi_data_t  m_axi_wdata;
	logic       m_axi_wvalid;
	logic       m_axi_wready;
	logic [1:0] m_axi_bresp;
	logic       m_axi_bvalid;
	logic       m_axi_bready;
	logic       wr_error;

	logic [15:0] lfsr = 16'd34;
	logic [1:0]  b_delay;
	logic        aw_done;
	logic        w_done;
	logic        err_seen;
	axi_addr_t   aw_addr_q;
	axi_data_t   w_data_q;
	int          cycle_cnt   = 0;
	int          idle_cnt    = 0;
	int          byte_cnt    = 0;
	int          frames_done = 0;
	int          stall_cnt   = 0;
	int          b_cnt       = 0;
	int          fail_cnt [1:6] = '{default: 0};
	int          total_fail;

	int          exp_kind;    // 0 UDP, 1 ARP, 2 ICMP
	int          exp_len;
	bit          hdr_known;
	byte_t       hdr_byte;
	axi_addr_t   exp_addr;
	axi_data_t   exp_data;

	eth_traffic_gen dut (.*);

	always #2 sys_clk = ~sys_clk;

	//////////////////////////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////////////////////////

	task automatic take_bit(output logic b);
		lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
		b    = lfsr[0];
	endtask

	task automatic record_fail(input int n, input string msg);
		$display("mismatch at %0t ns: test %0d, %s", $time, n, msg);
		fail_cnt[n] = fail_cnt[n] + 1;
	endtask

	task automatic report_test(input int n, input string name, input int hits);
		if (hits == 0) begin
			$display("test %0d %s: never exercised by the stimulus", n, name);
			fail_cnt[n] = fail_cnt[n] + 1;
		end
		$display("test %0d %s: %s, %0d checks reached, %0d errors", n, name,
			(fail_cnt[n] == 0) ? "ok" : "FAILED", hits, fail_cnt[n]);
	endtask

	function automatic int frame_length(input int kind);
		case (kind)
			1:       return `ETH_ARP_LEN;
			2:       return `ETH_ICMP_LEN;
			default: return `ETH_UDP_LEN;
		endcase
	endfunction

	function automatic bit header_checked(input int kind, input int idx);
		if (idx < 6 || idx == 12 || idx == 13)
			return 1'b1;
		return (kind == 0) && (idx >= 42) && (idx <= 45);
	endfunction

	function automatic byte_t header_byte(input int kind, input int idx);
		logic [47:0] mac;
		logic [15:0] etype;
		logic [31:0] flag;
		mac   = (kind == 1) ? 48'hFFFF_FFFF_FFFF : `ETH_FPGA_MAC;   // ARP is broadcast
		etype = (kind == 1) ? `ETH_TYPE_ARP : `ETH_TYPE_IP;
		flag  = `ETH_UDP_FLAG;
		if (idx < 6)
			return mac[8*(5-idx) +: 8];
		if (idx == 12)
			return etype[15:8];
		if (idx == 13)
			return etype[7:0];
		if (idx >= 42 && idx <= 45)
			return flag[8*(45-idx) +: 8];
		return 8'h00;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Reference model and slave
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		exp_kind  = (frames_done / `ETH_GROUP_FRAMES) % 3;
		exp_len   = frame_length(exp_kind);
		hdr_known = header_checked(exp_kind, byte_cnt);
		hdr_byte  = header_byte(exp_kind, byte_cnt);
		if ((b_cnt % WRITES_PER_BLOCK) < `BLK_WORDS) begin
			exp_addr = `BLK_BASE_ADDR + axi_addr_t'(4 * (b_cnt % WRITES_PER_BLOCK));
			exp_data = axi_data_t'((b_cnt / WRITES_PER_BLOCK) * 256 + b_cnt % WRITES_PER_BLOCK);
		end else begin
			exp_addr = `BLK_BASE_ADDR + `BLK_SUM_OFFSET;
			exp_data = axi_data_t'(`BLK_WORDS * 256 * (b_cnt / WRITES_PER_BLOCK)
				+ `BLK_WORDS * (`BLK_WORDS - 1) / 2);
		end
	end

	always @(posedge sys_clk) begin
		if (sys_rst) begin
			aw_done  <= 1'b0;
			w_done   <= 1'b0;
			err_seen <= 1'b0;
			idle_cnt <= 0;
			byte_cnt <= 0;
		end else begin
			cycle_cnt <= cycle_cnt + 1;
			idle_cnt  <= rx_valid ? 0 : idle_cnt + 1;
			if (rx_valid && !rx_ready)
				stall_cnt <= stall_cnt + 1;
			if (rx_valid && rx_ready) begin
				if (rx_last) begin
					byte_cnt    <= 0;
					frames_done <= frames_done + 1;
				end else begin
					byte_cnt <= byte_cnt + 1;
				end
			end
			if (m_axi_awvalid && m_axi_awready) begin
				aw_done   <= 1'b1;
				aw_addr_q <= m_axi_awaddr;
			end
			if (m_axi_wvalid && m_axi_wready) begin
				w_done   <= 1'b1;
				w_data_q <= m_axi_wdata;
			end
			if (m_axi_bvalid && m_axi_bready) begin
				aw_done <= 1'b0;
				w_done  <= 1'b0;
				b_cnt   <= b_cnt + 1;
				if (m_axi_bresp != 2'b00)
					err_seen <= 1'b1;
			end
		end
	end

	// Random back-pressure and B delay
	always @(negedge sys_clk) begin : drive_inputs
		logic b0;
		logic b1;
		take_bit(b0);
		take_bit(b1);
		rx_ready <= b0 | b1;
		take_bit(b0);
		m_axi_awready <= b0;
		take_bit(b0);
		m_axi_wready <= b0;
		if (!(aw_done && w_done)) begin
			m_axi_bvalid <= 1'b0;
			take_bit(b0);
			take_bit(b1);
			b_delay <= {b1, b0};
		end else if (!m_axi_bvalid) begin
			if (b_delay == 2'd0) begin
				m_axi_bvalid <= 1'b1;
				m_axi_bresp  <= (b_cnt == ERR_WRITE) ? 2'b10 : 2'b00;   // SLVERR
			end else begin
				b_delay <= b_delay - 2'd1;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Assertions
	//////////////////////////////////////////////////////////////////////

	a_hold: assert property (@(posedge sys_clk) disable iff (sys_rst)
		rx_valid && !rx_ready |=> rx_valid && $stable(rx_data) && $stable(rx_last))
		else record_fail(1, "stream byte changed while stalled");

	a_gap_start: assert property (@(posedge sys_clk) disable iff (sys_rst)
		rx_valid && rx_ready && rx_last |=> !rx_valid)
		else record_fail(1, "rx_valid stayed high after the last byte");

	a_gap: assert property (@(posedge sys_clk) disable iff (sys_rst)
		$rose(rx_valid) && frames_done > 0 |-> idle_cnt == `ETH_GAP_CYCLES)
		else record_fail(1, "idle gap after frame has wrong length");

	a_length: assert property (@(posedge sys_clk) disable iff (sys_rst)
		rx_valid && rx_ready |-> rx_last == (byte_cnt == exp_len - 1))
		else record_fail(2, "last flag not on the expected byte for this frame kind");

	a_header: assert property (@(posedge sys_clk) disable iff (sys_rst)
		rx_valid && rx_ready && hdr_known |-> rx_data == hdr_byte)
		else record_fail(3, "header byte differs from the expected field");

	a_aw_hold: assert property (@(posedge sys_clk) disable iff (sys_rst)
		m_axi_awvalid && !m_axi_awready |=> m_axi_awvalid && $stable(m_axi_awaddr))
		else record_fail(4, "awaddr or awvalid changed before accept");

	a_w_hold: assert property (@(posedge sys_clk) disable iff (sys_rst)
		m_axi_wvalid && !m_axi_wready |=> m_axi_wvalid && $stable(m_axi_wdata))
		else record_fail(4, "wdata or wvalid changed before accept");

	a_rise: assert property (@(posedge sys_clk) disable iff (sys_rst)
		$rose(m_axi_awvalid) == $rose(m_axi_wvalid))
		else record_fail(4, "awvalid and wvalid did not rise together");

	a_single: assert property (@(posedge sys_clk) disable iff (sys_rst)
		!(m_axi_awvalid && aw_done) && !(m_axi_wvalid && w_done))
		else record_fail(4, "new write issued before the previous response");

	a_bready: assert property (@(posedge sys_clk) disable iff (sys_rst)
		m_axi_bready |-> aw_done && w_done)
		else record_fail(4, "bready raised before address and data were accepted");

	a_block: assert property (@(posedge sys_clk) disable iff (sys_rst)
		m_axi_bvalid && m_axi_bready |-> aw_addr_q == exp_addr && w_data_q == exp_data)
		else record_fail(5, "block write address or data wrong");

	a_error: assert property (@(posedge sys_clk) disable iff (sys_rst)
		wr_error == err_seen)
		else record_fail(6, "wr_error does not follow the SLVERR response");

	//////////////////////////////////////////////////////////////////////
	// Run control
	//////////////////////////////////////////////////////////////////////

	initial begin
		sys_rst       = 1'b1;
		rx_ready      = 1'b0;
		m_axi_awready = 1'b0;
		m_axi_wready  = 1'b0;
		m_axi_bvalid  = 1'b0;
		m_axi_bresp   = 2'b00;
		repeat (2) @(posedge sys_clk);
		@(negedge sys_clk);
		sys_rst = 1'b0;

		wait (frames_done >= FRAMES_RUN);
		report_test(1, "stream stability", stall_cnt);
		report_test(2, "frame length and order", frames_done);
		report_test(3, "frame content", frames_done);

		wait (b_cnt >= BLOCKS_RUN * WRITES_PER_BLOCK);
		@(posedge sys_clk);
		report_test(4, "axi handshake", b_cnt);
		report_test(5, "block contents", b_cnt / WRITES_PER_BLOCK);
		report_test(6, "error flag", int'(err_seen));

		total_fail = 0;
		for (int i = 1; i <= 6; i++)
			total_fail += fail_cnt[i];
		$display("totals: %0d frames, %0d writes, %0d errors", frames_done, b_cnt, total_fail);
		if (total_fail == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

	initial begin
		wait (cycle_cnt >= TIMEOUT_CYCLES);
		$display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("TEST FAIL");
		$finish;
	end

endmodule

//--- files.f
+incdir+source
source/eth_pkg.sv
source/wr_req_if.sv
source/frame_rom.sv
source/frame_sequencer.sv
source/block_writer.sv
source/axil_write_master.sv
source/eth_traffic_gen.sv
testbench/tb_eth_traffic_gen.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_eth_traffic_gen
RTL_TOP   := eth_traffic_gen
FILELIST  := files.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^TEST PASS$$" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
